// File: decode_cluster.f
design/isa_pkg.sv
design/ctrl_pkg.sv
design/control_decode.sv
design/decode_lane.sv
design/decode_dispatch.sv
design/decode_collect.sv
design/decode_cluster.sv
bench/decode_cluster_chk.sv
bench/decode_cluster_tb.sv

// File: Bender.yml
package:
  name: decode_cluster

sources:
  - design/isa_pkg.sv
  - design/ctrl_pkg.sv
  - design/control_decode.sv
  - design/decode_lane.sv
  - design/decode_dispatch.sv
  - design/decode_collect.sv
  - design/decode_cluster.sv
  - target: test
    files:
      - bench/decode_cluster_chk.sv
      - bench/decode_cluster_tb.sv

// File: bench/decode_cluster_tb.sv
module decode_cluster_tb;

  import ctrl_pkg::*;

  localparam int NUM_LANES      = 4;
  localparam int DIRECTED_WORDS = 107;
  localparam int RANDOM_WORDS   = 60;
  localparam int WATCHDOG_CYCLES = (DIRECTED_WORDS + RANDOM_WORDS) * 40 + 200;

  logic           clk = 1'b0;
  logic           reset;
  logic           psel;
  logic           penable;
  logic           pwrite;
  logic [3:0]     paddr;
  logic [31:0]    pwdata;
  logic [31:0]    prdata;
  logic           pready;
  logic           pslverr;
  decode_result_t out_result;
  logic           out_valid;
  logic           out_ready;

  logic [31:0] ready_state = 32'h5178e90a;
  logic [31:0] word_state  = 32'h5178e90a;
  int          ready_mode  = 0;   // 0 random, 1 blocked, 2 open
  logic [31:0] exp_instr [$];
  logic        exp_stalled [$];
  logic        exp_squash [$];
  logic [7:0]  exp_seq = 8'h0;
  logic        pending_squash = 1'b0;
  logic [31:0] prev_word = 32'h0;
  int          pushes = 0;
  int          outputs = 0;
  int          apb_errors = 0;
  int          data_errors = 0;
  int          timeouts = 0;

  decode_cluster #(.NUM_LANES(NUM_LANES)) UUT
  (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .out_result (out_result),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // apb master
  //////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            output logic err, output logic [31:0] rdata);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    // sample away from the edge
    do
      @(negedge clk);
    while (!pready);
    err   = pslverr;
    rdata = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic expect_apb(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            input logic exp_err);
    logic        err;
    logic [31:0] rdata;
    apb_access(wr, addr, data, err, rdata);
    if (err !== exp_err)
    begin
      $display("ERROR pslverr addr %h got %h expected %h", addr, err, exp_err);
      apb_errors++;
    end
  endtask

  task automatic push_word(input logic [31:0] w);
    logic hazard;
    hazard = (prev_word[6:0] == 7'h03) && (prev_word[11:7] != 5'd0) &&
             ((prev_word[11:7] == w[19:15]) || (prev_word[11:7] == w[24:20]));
    exp_instr.push_back(w);
    exp_squash.push_back(pending_squash);
    exp_stalled.push_back(pending_squash || hazard || (w == 32'h0));
    pushes++;
    expect_apb(1'b1, 4'h0, w, 1'b0);
    pending_squash = 1'b0;
    prev_word      = w;
  endtask

  task automatic squash_next();
    expect_apb(1'b1, 4'h4, 32'h1, 1'b0);
    pending_squash = 1'b1;
  endtask

  task automatic check_status();
    logic        err;
    logic [31:0] rdata;
    apb_access(1'b0, 4'h8, 32'h0, err, rdata);
    if (err || rdata !== 32'(pushes - outputs))
    begin
      $display("ERROR prdata got %h expected %h", rdata, 32'(pushes - outputs));
      apb_errors++;
    end
  endtask

  task automatic drain();
    ready_mode = 2;
    while (outputs != pushes)
      @(posedge clk);
    ready_mode = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream sink and order check
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    ready_state = lcg_next(ready_state);
    if (ready_mode == 1)
      out_ready <= 1'b0;
    else if (ready_mode == 2)
      out_ready <= 1'b1;
    else
      out_ready <= ready_state[16];
  end

  always @(negedge clk)
  begin
    if (!reset && out_valid && out_ready)
    begin
      if (exp_instr.size() == 0)
      begin
        $display("output appeared with no word pending");
        data_errors++;
      end
      else
      begin
        if (out_result.instr !== exp_instr[0])
        begin
          $display("ERROR out_result.instr got %h expected %h", out_result.instr, exp_instr[0]);
          data_errors++;
        end
        if (out_result.stalled !== exp_stalled[0])
        begin
          $display("ERROR out_result.stalled got %h expected %h",
                   out_result.stalled, exp_stalled[0]);
          data_errors++;
        end
        if (out_result.squashed !== exp_squash[0])
        begin
          $display("ERROR out_result.squashed got %h expected %h",
                   out_result.squashed, exp_squash[0]);
          data_errors++;
        end
        if (out_result.seq !== exp_seq)
        begin
          $display("ERROR out_result.seq got %h expected %h", out_result.seq, exp_seq);
          data_errors++;
        end
        void'(exp_instr.pop_front());
        void'(exp_stalled.pop_front());
        void'(exp_squash.pop_front());
      end
      exp_seq = exp_seq + 8'd1;
      outputs++;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    timeouts++;
    $display("watchdog expired after %0d cycles with %0d of %0d outputs",
             WATCHDOG_CYCLES, outputs, pushes);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [6:0] ops [11];
    logic [6:0] f7s [3];
    int         total;
    ops = '{7'h03, 7'h33, 7'h13, 7'h23, 7'h63, 7'h6f, 7'h67, 7'h37, 7'h17, 7'h73, 7'h7f};
    f7s = '{7'h00, 7'h20, 7'h01};
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 4'h0;
    pwdata  = 32'h0;
    out_ready = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // arithmetic, every funct3 with base, alt and bad funct7
    for (int f = 0; f < 3; f++)
      for (int k = 0; k < 8; k++)
      begin
        push_word(encode(f7s[f], 5'd2, 5'd1, 3'(k), 5'd3, 7'h33));
        push_word(encode(f7s[f], 5'd2, 5'd1, 3'(k), 5'd3, 7'h13));
      end

    // loads and stores, rd never reused right after
    for (int k = 0; k < 8; k++)
    begin
      push_word(encode(7'h0, 5'd0, 5'd1, 3'(k), 5'd9, 7'h03));
      push_word(encode(7'h0, 5'd4, 5'd1, 3'(k), 5'd0, 7'h23));
    end
    for (int k = 0; k < 8; k++)
    begin
      push_word(encode(7'h0, 5'd2, 5'd1, 3'(k), 5'd0, 7'h63));
      push_word(encode(7'h0, 5'd0, 5'd1, 3'(k), 5'd5, 7'h73));
    end
    push_word(encode(7'h0, 5'd0, 5'd0, 3'd0, 5'd1, 7'h6f));
    push_word(encode(7'h0, 5'd0, 5'd2, 3'd0, 5'd1, 7'h67));
    push_word(encode(7'h12, 5'd3, 5'd4, 3'd5, 5'd1, 7'h37));
    push_word(encode(7'h12, 5'd3, 5'd4, 3'd5, 5'd1, 7'h17));

    // load-use, zero word and independent follower
    push_word(encode(7'h0, 5'd0, 5'd1, 3'd2, 5'd10, 7'h03));
    push_word(encode(7'h0, 5'd11, 5'd10, 3'd0, 5'd12, 7'h33));
    push_word(encode(7'h0, 5'd0, 5'd1, 3'd2, 5'd13, 7'h03));
    push_word(encode(7'h0, 5'd13, 5'd2, 3'd2, 5'd0, 7'h23));
    push_word(encode(7'h0, 5'd0, 5'd1, 3'd2, 5'd14, 7'h03));
    push_word(encode(7'h0, 5'd0, 5'd14, 3'd1, 5'd15, 7'h73));
    push_word(32'h0);
    push_word(encode(7'h0, 5'd0, 5'd1, 3'd2, 5'd16, 7'h03));
    push_word(encode(7'h0, 5'd8, 5'd7, 3'd0, 5'd9, 7'h33));

    // squash then a normal word, for each redirecting kind
    for (int k = 0; k < 4; k++)
    begin
      squash_next();
      push_word(encode(7'h0, 5'd2, 5'd1, 3'd6, 5'd1, ops[k == 0 ? 4 : k == 1 ? 5 :
                                                        k == 2 ? 6 : 10]));
      push_word(encode(7'h0, 5'd2, 5'd1, 3'd1, 5'd0, 7'h63));
    end
    drain();
    check_status();

    // apb error responses
    expect_apb(1'b0, 4'h0, 32'h0, 1'b1);
    expect_apb(1'b0, 4'h4, 32'h0, 1'b1);
    expect_apb(1'b1, 4'h8, 32'h0, 1'b1);
    expect_apb(1'b1, 4'hc, 32'h0, 1'b1);

    // fill all lanes and the output register with the stream blocked
    ready_mode = 1;
    repeat (2) @(posedge clk);
    for (int k = 0; k < NUM_LANES + 1; k++)
      push_word(encode(7'h0, 5'd2, 5'd1, 3'(k), 5'd3, 7'h13));
    repeat (4) @(posedge clk);
    check_status();
    fork
      push_word(encode(7'h20, 5'd2, 5'd1, 3'd5, 5'd3, 7'h33));
      begin
        repeat (30) @(posedge clk);
        ready_mode = 0;
      end
    join
    drain();

    // random words under random back-pressure
    for (int k = 0; k < RANDOM_WORDS; k++)
    begin
      word_state = lcg_next(word_state);
      if (word_state[31:28] == 4'hf)
        squash_next();
      push_word({word_state[31:7], ops[word_state[3:0] % 11]});
    end
    drain();
    check_status();

    total = apb_errors + data_errors + UUT.u_chk.fail_count + timeouts;
    $display("errors apb %0d data %0d assert %0d timeout %0d, pushes %0d outputs %0d",
             apb_errors, data_errors, UUT.u_chk.fail_count, timeouts, pushes, outputs);
    if (total == 0 && outputs == pushes)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: bench/decode_cluster_chk.sv
module decode_cluster_chk
(
  input logic                     clk,
  input logic                     reset,
  input ctrl_pkg::decode_result_t out_result,
  input logic                     out_valid,
  input logic                     out_ready
);

  import ctrl_pkg::*;

  int fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // reference RV32I control table
  //////////////////////////////////////////////////////////////////////

  function automatic control_word_t ref_ctrl(input logic [31:0] w, input logic sq,
                                             input logic st);
    control_word_t c;
    logic [6:0]    op;
    logic [2:0]    f3;
    logic [6:0]    f7;
    c  = '0;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    case (op)
      7'h03:
      begin
        c.memread  = 1'b1;
        c.regwrite = 1'b1;
        c.alusrc   = 1'b1;
        if (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2)
          c.loadcntrl = 5'b00001 << f3;
        else if (f3 == 3'd4 || f3 == 3'd5)
          c.loadcntrl = 5'b01000 << (f3 - 3'd4);
        else
          c.illegal_ins = 1'b1;
      end
      7'h33:
      begin
        c.regwrite = 1'b1;
        if (f7 == 7'h00)
        begin
          case (f3)
            3'd0: c.alusel = ADD;
            3'd1: c.alusel = SLL;
            3'd2: {c.compare, c.cmpcntrl} = 5'b1_0001;
            3'd3: {c.compare, c.cmpcntrl} = 5'b1_0010;
            3'd4: c.alusel = XOR;
            3'd5: c.alusel = SRL;
            3'd6: c.alusel = OR;
            default: c.alusel = AND;
          endcase
        end
        else if (f7 == 7'h20 && f3 == 3'd0)
          c.alusel = SUB;
        else if (f7 == 7'h20 && f3 == 3'd5)
          c.alusel = SRA;
        else
          c.illegal_ins = 1'b1;
      end
      7'h13:
      begin
        c.regwrite = 1'b1;
        c.alusrc   = 1'b1;
        case (f3)
          3'd0: c.alusel = ADD;
          3'd1:
            if (f7 == 7'h00)
              c.alusel = SLL;
            else
              c.illegal_ins = 1'b1;
          3'd2: {c.compare, c.cmpcntrl} = 5'b1_0100;
          3'd3: {c.compare, c.cmpcntrl} = 5'b1_1000;
          3'd4: c.alusel = XOR;
          3'd5:
            if (f7 == 7'h00)
              c.alusel = SRL;
            else if (f7 == 7'h20)
              c.alusel = SRA;
            else
              c.illegal_ins = 1'b1;
          3'd6: c.alusel = OR;
          default: c.alusel = AND;
        endcase
      end
      7'h23:
      begin
        c.memwrite = 1'b1;
        c.alusrc   = 1'b1;
        if (f3 <= 3'd2)
          c.storecntrl = 3'b001 << f3;
        else
          c.illegal_ins = 1'b1;
      end
      7'h63:
      begin
        c.branch = 1'b1;
        case (f3)
          3'd0: c.beq = 1'b1;
          3'd1: c.bne = 1'b1;
          3'd2: c.blt = 1'b1;
          3'd3: c.bge = 1'b1;
          3'd4: c.bltu = 1'b1;
          3'd5: c.bgeu = 1'b1;
          default: c.illegal_ins = 1'b1;
        endcase
      end
      7'h6f: {c.jal, c.regwrite} = 2'b11;
      7'h67: {c.jalr, c.regwrite} = 2'b11;
      7'h37: {c.lui, c.alusrc, c.regwrite} = 3'b111;
      7'h17: {c.auipc, c.alusrc, c.regwrite} = 3'b111;
      7'h73:
      begin
        c.csrsel   = f3;
        c.regwrite = 1'b1;
        c.csrwrite = 1'b1;
        c.alusrc   = f3[2];
      end
      default: c.illegal_ins = 1'b1;
    endcase
    // a stalled slot writes nothing
    if (st)
    begin
      c.regwrite = 1'b0;
      c.memwrite = 1'b0;
      c.csrwrite = 1'b0;
    end
    if (sq)
    begin
      c.branch      = 1'b0;
      c.jal         = 1'b0;
      c.jalr        = 1'b0;
      c.illegal_ins = 1'b0;
    end
    return c;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stream properties
  //////////////////////////////////////////////////////////////////////

  a_decode: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_result.ctrl ==
      ref_ctrl(out_result.instr, out_result.squashed, out_result.stalled))
    else
    begin
      $error("control word differs from reference for instr %h", out_result.instr);
      fail_count++;
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result))
    else
    begin
      $error("output changed while stream stalled");
      fail_count++;
    end

  a_seq: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_ready ##1 out_valid |-> out_result.seq == $past(out_result.seq) + 8'd1)
    else
    begin
      $error("seq did not advance by one");
      fail_count++;
    end

endmodule

bind decode_cluster decode_cluster_chk u_chk
(
  .clk        (clk),
  .reset      (reset),
  .out_result (out_result),
  .out_valid  (out_valid),
  .out_ready  (out_ready)
);

// File: design/decode_cluster.sv
module decode_cluster #(
  parameter int NUM_LANES = 4
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [3:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output ctrl_pkg::decode_result_t out_result,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import ctrl_pkg::*;

  dispatch_item_t lane_item;
  logic           lane_valid [NUM_LANES];
  logic           lane_ready [NUM_LANES];
  decode_result_t lane_result [NUM_LANES];
  logic           lane_done [NUM_LANES];
  logic           lane_take [NUM_LANES];
  logic           retire;

  decode_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch
  (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .lane_item  (lane_item),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .retire     (retire)
  );

  // every lane sees the same item, only the addressed one accepts
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : gen_lane
    decode_lane u_lane
    (
      .clk      (clk),
      .reset    (reset),
      .item     (lane_item),
      .in_valid (lane_valid[i]),
      .in_ready (lane_ready[i]),
      .result   (lane_result[i]),
      .done     (lane_done[i]),
      .take     (lane_take[i])
    );
  end

  decode_collect #(.NUM_LANES(NUM_LANES)) u_collect
  (
    .clk         (clk),
    .reset       (reset),
    .lane_result (lane_result),
    .lane_done   (lane_done),
    .lane_take   (lane_take),
    .out_result  (out_result),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .retire      (retire)
  );

endmodule

// File: design/decode_collect.sv
module decode_collect #(
  parameter int NUM_LANES = 4
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  ctrl_pkg::decode_result_t lane_result [NUM_LANES],
  input  logic                     lane_done [NUM_LANES],
  output logic                     lane_take [NUM_LANES],
  output ctrl_pkg::decode_result_t out_result,
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic                     retire
);

  typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;

  lane_id_t   ptr;
  logic [7:0] seq;
  logic       take;

  //////////////////////////////////////////////////////////////////////
  // head lane selection
  //////////////////////////////////////////////////////////////////////

  // pointer follows issue order, so only the head lane may move
  assign take   = lane_done[ptr] && (!out_valid || out_ready);
  assign retire = out_valid && out_ready;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      lane_take[i] = take && (lane_id_t'(i) == ptr);
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr       <= '0;
      seq       <= 8'h0;
      out_valid <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        ptr       <= ptr + 1'b1;
        seq       <= seq + 8'd1;
        out_valid <= 1'b1;
      end
      else if (out_ready)
        out_valid <= 1'b0;
    end
  end

  // held while the stream is stalled
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_result     <= lane_result[ptr];
      out_result.seq <= seq;
    end
  end

endmodule

// File: design/decode_dispatch.sv
module decode_dispatch #(
  parameter int NUM_LANES = 4
)
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [3:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output ctrl_pkg::dispatch_item_t lane_item,
  output logic                     lane_valid [NUM_LANES],
  input  logic                     lane_ready [NUM_LANES],
  input  logic                     retire
);

  import isa_pkg::*;

  typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;

  // lanes plus the output register
  localparam int CNT_W = $clog2(NUM_LANES + 2);

  localparam logic [3:0] ADDR_INSTR  = 4'h0;
  localparam logic [3:0] ADDR_CTRL   = 4'h4;
  localparam logic [3:0] ADDR_STATUS = 4'h8;

  lane_id_t         ptr;
  logic             squash;
  logic             prev_load;
  logic [4:0]       prev_rd;
  logic [CNT_W-1:0] in_flight;
  instr_fields_t    fields;
  logic             access;
  logic             instr_wr;
  logic             ctrl_wr;
  logic             status_rd;
  logic             issue;
  logic             hazard;

  //////////////////////////////////////////////////////////////////////
  // apb decode
  //////////////////////////////////////////////////////////////////////

  assign access    = psel && penable;
  assign instr_wr  = access && pwrite && (paddr == ADDR_INSTR);
  assign ctrl_wr   = access && pwrite && (paddr == ADDR_CTRL);
  assign status_rd = access && !pwrite && (paddr == ADDR_STATUS);
  assign issue     = instr_wr && lane_ready[ptr];

  // only a push to a busy lane waits
  assign pready  = access && (!instr_wr || lane_ready[ptr]);
  assign pslverr = access && !(instr_wr || ctrl_wr || status_rd);
  assign prdata  = status_rd ? 32'(in_flight) : 32'h0;

  //////////////////////////////////////////////////////////////////////
  // load-use check and issue
  //////////////////////////////////////////////////////////////////////

  assign fields = instr_fields_t'(pwdata);

  // previous word loads a register this one reads
  assign hazard = prev_load && (prev_rd != 5'd0) &&
                  ((prev_rd == fields.rs1) || (prev_rd == fields.rs2));

  assign lane_item = '{instr: pwdata, hazard: hazard, squash: squash};

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      lane_valid[i] = instr_wr && (lane_id_t'(i) == ptr);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr       <= '0;
      squash    <= 1'b0;
      prev_load <= 1'b0;
      in_flight <= '0;
    end
    else
    begin
      if (issue)
      begin
        ptr       <= ptr + 1'b1;
        squash    <= 1'b0;
        prev_load <= (fields.opcode == LOAD);
      end
      else if (ctrl_wr && pwdata[0])
        squash <= 1'b1;
      in_flight <= in_flight + CNT_W'(issue) - CNT_W'(retire);
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      prev_rd <= fields.rd;
  end

endmodule

// File: design/decode_lane.sv
module decode_lane
(
  input  logic                     clk,
  input  logic                     reset,
  input  ctrl_pkg::dispatch_item_t item,
  input  logic                     in_valid,
  output logic                     in_ready,
  output ctrl_pkg::decode_result_t result,
  output logic                     done,
  input  logic                     take
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  instr_fields_t fields;
  control_word_t ctrl;
  logic          ins_zero;
  logic          accept;

  assign fields   = instr_fields_t'(item.instr);
  assign ins_zero = (item.instr == 32'h0);

  // free again in the cycle the collector takes the result
  assign in_ready = !done || take;
  assign accept   = in_valid && in_ready;

  control_decode u_decode
  (
    .fields   (fields),
    .ins_zero (ins_zero),
    .flush    (item.squash),
    .hazard   (item.hazard),
    .ctrl     (ctrl)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
      done <= 1'b0;
    else if (accept)
      done <= 1'b1;
    else if (take)
      done <= 1'b0;
  end

  // seq is stamped later by the collector
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      result.seq      <= 8'h0;
      result.instr    <= item.instr;
      result.squashed <= item.squash;
      result.stalled  <= item.squash || item.hazard || ins_zero;
      result.ctrl     <= ctrl;
    end
  end

endmodule

// File: design/control_decode.sv
module control_decode
(
  input  isa_pkg::instr_fields_t  fields,
  input  logic                    ins_zero,
  input  logic                    flush,
  input  logic                    hazard,
  output ctrl_pkg::control_word_t ctrl
);

  import isa_pkg::*;
  import ctrl_pkg::*;

  control_word_t raw;
  logic          stall;

  assign stall = flush || hazard || ins_zero;

  //////////////////////////////////////////////////////////////////////
  // opcode table, before stall and flush
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    raw = '0;
    unique case (fields.opcode)
      LOAD:
      begin
        raw.memread  = 1'b1;
        raw.regwrite = 1'b1;
        raw.alusrc   = 1'b1;
        raw.alusel   = ADD;
        case (fields.funct3)
          F3_B:    raw.loadcntrl = 5'b00001;
          F3_H:    raw.loadcntrl = 5'b00010;
          F3_W:    raw.loadcntrl = 5'b00100;
          F3_BU:   raw.loadcntrl = 5'b01000;
          F3_HU:   raw.loadcntrl = 5'b10000;
          default: raw.illegal_ins = 1'b1;
        endcase
      end
      OP:
      begin
        raw.regwrite = 1'b1;
        case ({fields.funct7, fields.funct3})
          {F7_BASE, F3_ADD}: raw.alusel = ADD;
          {F7_ALT, F3_ADD}:  raw.alusel = SUB;
          {F7_BASE, F3_SLL}: raw.alusel = SLL;
          {F7_BASE, F3_SLT}:
          begin
            raw.compare  = 1'b1;
            raw.cmpcntrl = 4'b0001;
          end
          {F7_BASE, F3_SLTU}:
          begin
            raw.compare  = 1'b1;
            raw.cmpcntrl = 4'b0010;
          end
          {F7_BASE, F3_XOR}: raw.alusel = XOR;
          {F7_BASE, F3_SR}:  raw.alusel = SRL;
          {F7_ALT, F3_SR}:   raw.alusel = SRA;
          {F7_BASE, F3_OR}:  raw.alusel = OR;
          {F7_BASE, F3_AND}: raw.alusel = AND;
          default:           raw.illegal_ins = 1'b1;
        endcase
      end
      OP_IMM:
      begin
        raw.regwrite = 1'b1;
        raw.alusrc   = 1'b1;
        case (fields.funct3)
          F3_ADD: raw.alusel = ADD;
          F3_SLL:
          begin
            // shamt is 5 bits, upper funct7 must be clear
            if (fields.funct7 == F7_BASE)
              raw.alusel = SLL;
            else
              raw.illegal_ins = 1'b1;
          end
          F3_SLT:
          begin
            raw.compare  = 1'b1;
            raw.cmpcntrl = 4'b0100;
          end
          F3_SLTU:
          begin
            raw.compare  = 1'b1;
            raw.cmpcntrl = 4'b1000;
          end
          F3_XOR: raw.alusel = XOR;
          F3_SR:
          begin
            if (fields.funct7 == F7_BASE)
              raw.alusel = SRL;
            else if (fields.funct7 == F7_ALT)
              raw.alusel = SRA;
            else
              raw.illegal_ins = 1'b1;
          end
          F3_OR:   raw.alusel = OR;
          default: raw.alusel = AND;
        endcase
      end
      STORE:
      begin
        raw.memwrite = 1'b1;
        raw.alusrc   = 1'b1;
        raw.alusel   = ADD;
        case (fields.funct3)
          F3_B:    raw.storecntrl = 3'b001;
          F3_H:    raw.storecntrl = 3'b010;
          F3_W:    raw.storecntrl = 3'b100;
          default: raw.illegal_ins = 1'b1;
        endcase
      end
      BRANCH:
      begin
        raw.branch = 1'b1;
        case (fields.funct3)
          F3_BEQ:  raw.beq = 1'b1;
          F3_BNE:  raw.bne = 1'b1;
          F3_BLT:  raw.blt = 1'b1;
          F3_BGE:  raw.bge = 1'b1;
          F3_BLTU: raw.bltu = 1'b1;
          F3_BGEU: raw.bgeu = 1'b1;
          default: raw.illegal_ins = 1'b1;
        endcase
      end
      JAL:
      begin
        raw.jal      = 1'b1;
        raw.regwrite = 1'b1;
      end
      JALR:
      begin
        raw.jalr     = 1'b1;
        raw.regwrite = 1'b1;
      end
      LUI:
      begin
        raw.lui      = 1'b1;
        raw.alusrc   = 1'b1;
        raw.regwrite = 1'b1;
      end
      AUIPC:
      begin
        raw.auipc    = 1'b1;
        raw.alusrc   = 1'b1;
        raw.regwrite = 1'b1;
      end
      SYSTEM:
      begin
        raw.csrsel   = fields.funct3;
        raw.regwrite = 1'b1;
        raw.csrwrite = 1'b1;
        // csrrwi, csrrsi, csrrci take the zimm operand
        raw.alusrc   = fields.funct3[2];
      end
      default:
        raw.illegal_ins = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // stall and flush masking
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl = raw;
    // no architectural write from a stalled slot
    ctrl.regwrite    = raw.regwrite && !stall;
    ctrl.memwrite    = raw.memwrite && !stall;
    ctrl.csrwrite    = raw.csrwrite && !stall;
    // squashed word redirects nothing and traps on nothing
    ctrl.branch      = raw.branch && !flush;
    ctrl.jal         = raw.jal && !flush;
    ctrl.jalr        = raw.jalr && !flush;
    ctrl.illegal_ins = raw.illegal_ins && !flush;
  end

endmodule

// File: design/ctrl_pkg.sv
package ctrl_pkg;

  // alu function select
  typedef enum logic [2:0] {
    ADD = 3'b000,
    SUB = 3'b001,
    AND = 3'b010,
    OR  = 3'b011,
    XOR = 3'b100,
    SLL = 3'b101,
    SRL = 3'b110,
    SRA = 3'b111
  } alu_sel_e;

  typedef struct packed {
    alu_sel_e   alusel;
    logic [2:0] storecntrl;  // sw sh sb
    logic [4:0] loadcntrl;   // lhu lbu lw lh lb
    logic [3:0] cmpcntrl;    // sltiu slti sltu slt
    logic       branch;
    logic       beq;
    logic       bne;
    logic       blt;
    logic       bge;
    logic       bltu;
    logic       bgeu;
    logic       memread;
    logic       memwrite;
    logic       regwrite;
    logic       alusrc;
    logic       compare;
    logic       auipc;
    logic       lui;
    logic       jal;
    logic       jalr;
    logic       illegal_ins;
    logic [2:0] csrsel;
    logic       csrwrite;
  } control_word_t;

  // one pushed word on its way to a lane
  typedef struct packed {
    logic [31:0] instr;
    logic        hazard;
    logic        squash;
  } dispatch_item_t;

  typedef struct packed {
    logic [7:0]    seq;
    logic [31:0]   instr;
    logic          squashed;
    logic          stalled;
    control_word_t ctrl;
  } decode_result_t;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

  // base opcodes
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // funct7 selects base or alternate form
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  // arithmetic funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // load and store widths
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // branch conditions, as this core numbers them
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b010;
  localparam logic [2:0] F3_BGE  = 3'b011;
  localparam logic [2:0] F3_BLTU = 3'b100;
  localparam logic [2:0] F3_BGEU = 3'b101;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_fields_t;

endpackage
